// File: hw/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    // frame start pair on the host stream
    localparam logic [7:0] sync_byte_0 = 8'hAA;
    localparam logic [7:0] sync_byte_1 = 8'h55;

    // first byte of every upload response
    localparam logic [7:0] resp_sync = 8'hA5;

    // command codes
    localparam logic [7:0] cmd_pwm_set  = 8'h01;
    localparam logic [7:0] cmd_loopback = 8'h02;

    // source tags in the upload header
    localparam logic [7:0] src_pwm      = 8'h01;
    localparam logic [7:0] src_loopback = 8'h02;

    // payload buffer sizing
    localparam int max_payload    = 64;
    localparam int payload_addr_w = $clog2(max_payload);

    localparam int pwm_channels = 8;

endpackage

`default_nettype wire

// File: hw/cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cmd_if;

    logic [7:0]  cmd_type;
    logic [15:0] cmd_length;
    logic [7:0]  cmd_data;
    logic [15:0] cmd_data_index;
    logic        cmd_start;
    logic        cmd_data_valid;
    logic        cmd_done;
    // one ready level per handler
    logic        pwm_ready;
    logic        lb_ready;

    modport source (
        output cmd_type, cmd_length, cmd_data, cmd_data_index,
        output cmd_start, cmd_data_valid, cmd_done,
        input  pwm_ready, lb_ready
    );

    modport sink (
        input  cmd_type, cmd_length, cmd_data, cmd_data_index,
        input  cmd_start, cmd_data_valid, cmd_done,
        output pwm_ready, lb_ready
    );

endinterface

`default_nettype wire

// File: hw/upload_if.sv
`timescale 1ns/1ps
`default_nettype none

interface upload_if;

    logic       req;
    logic [7:0] data;
    logic       valid;
    // marks the final byte of a response
    logic       last;

    modport source (
        output req, data, valid, last
    );

    modport sink (
        input req, data, valid, last
    );

endinterface

`default_nettype wire

// File: hw/frame_parser.sv
`timescale 1ns/1ps
`default_nettype none

module frame_parser
    import bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [7:0]                rx_data,
    input  logic                      rx_valid,
    input  logic [payload_addr_w-1:0] rd_addr,
    output logic [7:0]                rd_data,
    output logic                      parse_done,
    output logic                      parse_error,
    output logic [7:0]                cmd_code,
    output logic [15:0]               cmd_len
);

    typedef enum logic [2:0] {
        p_sync0, p_sync1, p_cmd, p_len_h, p_len_l, p_payload, p_csum
    } p_state_t;

    p_state_t    state;
    logic [7:0]  sum;
    logic [7:0]  code_q;
    logic [15:0] len_q;
    logic [15:0] byte_cnt;
    logic        too_long;
    logic [7:0]  mem [max_payload];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= p_sync0;
            sum         <= 8'd0;
            code_q      <= 8'd0;
            len_q       <= 16'd0;
            byte_cnt    <= 16'd0;
            too_long    <= 1'b0;
            parse_done  <= 1'b0;
            parse_error <= 1'b0;
            cmd_code    <= 8'd0;
            cmd_len     <= 16'd0;
        end else begin
            parse_done  <= 1'b0;
            parse_error <= 1'b0;
            if (rx_valid) begin
                case (state)
                    p_sync0: begin
                        if (rx_data == sync_byte_0) state <= p_sync1;
                    end
                    p_sync1: begin
                        // a repeated AA may still start the frame
                        if (rx_data == sync_byte_1) state <= p_cmd;
                        else if (rx_data != sync_byte_0) state <= p_sync0;
                    end
                    p_cmd: begin
                        code_q <= rx_data;
                        sum    <= rx_data;
                        state  <= p_len_h;
                    end
                    p_len_h: begin
                        len_q[15:8] <= rx_data;
                        sum         <= sum + rx_data;
                        state       <= p_len_l;
                    end
                    p_len_l: begin
                        len_q[7:0] <= rx_data;
                        sum        <= sum + rx_data;
                        byte_cnt   <= 16'd0;
                        too_long   <= {len_q[15:8], rx_data} > 16'(max_payload);
                        if ({len_q[15:8], rx_data} == 16'd0) state <= p_csum;
                        else state <= p_payload;
                    end
                    p_payload: begin
                        // oversized payloads are still consumed, just not stored
                        sum      <= sum + rx_data;
                        byte_cnt <= byte_cnt + 16'd1;
                        if (byte_cnt == len_q - 16'd1) state <= p_csum;
                    end
                    p_csum: begin
                        state <= p_sync0;
                        if (!too_long && rx_data == sum) begin
                            parse_done <= 1'b1;
                            cmd_code   <= code_q;
                            cmd_len    <= len_q;
                        end else begin
                            parse_error <= 1'b1;
                        end
                    end
                    default: state <= p_sync0;
                endcase
            end
        end
    end

    // payload buffer, one cycle read latency
    always_ff @(posedge clk) begin
        if (rx_valid && state == p_payload && !too_long) begin
            mem[byte_cnt[payload_addr_w-1:0]] <= rx_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: hw/command_processor.sv
`timescale 1ns/1ps
`default_nettype none

module command_processor
    import bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      parse_done,
    input  logic [7:0]                cmd_code,
    input  logic [15:0]               cmd_len,
    output logic [payload_addr_w-1:0] rd_addr,
    input  logic [7:0]                rd_data,
    cmd_if.source                     cmd,
    output logic                      led_out
);

    logic                    busy;
    logic                    pend;
    logic                    rd_q;
    logic [payload_addr_w:0] rd_idx;
    logic [payload_addr_w:0] idx_q;
    logic                    rd_act;
    logic                    go;
    logic                    finish;

    // a read is issued every cycle until the whole payload is requested
    assign rd_act  = busy && (16'(rd_idx) < cmd.cmd_length);
    assign rd_addr = rd_idx[payload_addr_w-1:0];
    assign go      = !busy && (parse_done || pend) && cmd.pwm_ready && cmd.lb_ready;
    assign finish  = (cmd.cmd_data_valid && cmd.cmd_data_index == cmd.cmd_length - 16'd1)
                   || (cmd.cmd_start && cmd.cmd_length == 16'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy               <= 1'b0;
            pend               <= 1'b0;
            rd_q               <= 1'b0;
            rd_idx             <= '0;
            led_out            <= 1'b0;
            cmd.cmd_type       <= 8'd0;
            cmd.cmd_length     <= 16'd0;
            cmd.cmd_start      <= 1'b0;
            cmd.cmd_data_valid <= 1'b0;
            cmd.cmd_done       <= 1'b0;
        end else begin
            cmd.cmd_start      <= go;
            cmd.cmd_done       <= finish;
            rd_q               <= rd_act;
            cmd.cmd_data_valid <= rd_q;
            if (go) begin
                busy           <= 1'b1;
                pend           <= 1'b0;
                led_out        <= ~led_out;
                cmd.cmd_type   <= cmd_code;
                cmd.cmd_length <= cmd_len;
                rd_idx         <= '0;
            end else begin
                // a frame that lands while busy waits here
                if (parse_done) pend <= 1'b1;
                if (rd_act) rd_idx <= rd_idx + 1'b1;
                if (finish) busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        idx_q              <= rd_idx;
        cmd.cmd_data       <= rd_data;
        cmd.cmd_data_index <= 16'(idx_q);
    end

endmodule

`default_nettype wire

// File: hw/pwm_handler.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_handler
    import bridge_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    cmd_if.sink                     cmd,
    upload_if.source                up,
    output logic [pwm_channels-1:0] pwm_pins
);

    logic [7:0]                    duty [pwm_channels];
    logic [7:0]                    shadow [pwm_channels];
    logic [7:0]                    pwm_cnt;
    logic                          active;
    logic                          start;
    logic                          take;
    logic [$clog2(pwm_channels):0] applied;

    assign start = cmd.cmd_start && cmd.cmd_type == cmd_pwm_set;
    // bytes past the last channel are dropped
    assign take  = active && cmd.cmd_data_valid && cmd.cmd_data_index < 16'(pwm_channels);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active        <= 1'b0;
            applied       <= '0;
            cmd.pwm_ready <= 1'b1;
            up.req        <= 1'b0;
            up.valid      <= 1'b0;
            up.last       <= 1'b0;
            pwm_cnt       <= 8'd0;
            pwm_pins      <= '0;
            for (int k = 0; k < pwm_channels; k++) begin
                duty[k] <= 8'd0;
            end
        end else begin
            pwm_cnt  <= pwm_cnt + 8'd1;
            // req, then the single ack byte
            up.req   <= active && cmd.cmd_done;
            up.valid <= up.req;
            up.last  <= up.req;
            if (start) begin
                active        <= 1'b1;
                applied       <= '0;
                cmd.pwm_ready <= 1'b0;
            end else if (take) begin
                applied <= applied + 1'b1;
            end
            if (active && cmd.cmd_done) begin
                active <= 1'b0;
                for (int k = 0; k < pwm_channels; k++) begin
                    duty[k] <= shadow[k];
                end
            end
            if (up.valid) cmd.pwm_ready <= 1'b1;
            for (int k = 0; k < pwm_channels; k++) begin
                pwm_pins[k] <= pwm_cnt < duty[k];
            end
        end
    end

    // shadow starts from the live set so untouched channels keep their value
    always_ff @(posedge clk) begin
        if (start) begin
            for (int k = 0; k < pwm_channels; k++) begin
                shadow[k] <= duty[k];
            end
        end else if (take) begin
            shadow[cmd.cmd_data_index[$clog2(pwm_channels)-1:0]] <= cmd.cmd_data;
        end
        if (up.req) up.data <= 8'(applied);
    end

endmodule

`default_nettype wire

// File: hw/loopback_handler.sv
`timescale 1ns/1ps
`default_nettype none

module loopback_handler
    import bridge_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    cmd_if.sink      cmd,
    upload_if.source up
);

    logic active;
    logic start;
    logic is_last;

    // empty loopback commands are answered with nothing
    assign start   = cmd.cmd_start && cmd.cmd_type == cmd_loopback
                   && cmd.cmd_length != 16'd0;
    assign is_last = cmd.cmd_data_index == cmd.cmd_length - 16'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active       <= 1'b0;
            cmd.lb_ready <= 1'b1;
            up.req       <= 1'b0;
            up.valid     <= 1'b0;
            up.last      <= 1'b0;
        end else begin
            up.req   <= 1'b0;
            up.valid <= 1'b0;
            up.last  <= 1'b0;
            if (start) begin
                active       <= 1'b1;
                cmd.lb_ready <= 1'b0;
                up.req       <= 1'b1;
            end else if (active && cmd.cmd_data_valid) begin
                up.valid <= 1'b1;
                up.last  <= is_last;
                if (is_last) begin
                    active       <= 1'b0;
                    cmd.lb_ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active && cmd.cmd_data_valid) up.data <= cmd.cmd_data;
    end

endmodule

`default_nettype wire

// File: hw/upload_merger.sv
`timescale 1ns/1ps
`default_nettype none

module upload_merger
    import bridge_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    upload_if.sink     pwm_up,
    upload_if.sink     lb_up,
    output logic [7:0] upload_data,
    output logic       upload_valid
);

    typedef enum logic [1:0] {m_idle, m_tag, m_data} m_state_t;

    m_state_t   state;
    logic       sel_lb;
    logic       pend_pwm;
    logic       pend_lb;
    // {last, data} held while the header goes out
    logic [8:0] skid [2];
    logic [1:0] skid_cnt;
    logic [1:0] wr_slot;
    logic       in_valid;
    logic [8:0] in_byte;
    logic [8:0] out_byte;
    logic       pop;
    logic       push;
    logic       fwd;

    assign in_valid = sel_lb ? lb_up.valid : pwm_up.valid;
    assign in_byte  = sel_lb ? {lb_up.last, lb_up.data} : {pwm_up.last, pwm_up.data};
    assign out_byte = (skid_cnt != 2'd0) ? skid[0] : in_byte;
    assign pop      = state == m_data && skid_cnt != 2'd0;
    assign push     = in_valid && state != m_idle && !(state == m_data && skid_cnt == 2'd0);
    assign fwd      = state == m_data && (skid_cnt != 2'd0 || in_valid);
    assign wr_slot  = skid_cnt - 2'(pop);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= m_idle;
            sel_lb       <= 1'b0;
            pend_pwm     <= 1'b0;
            pend_lb      <= 1'b0;
            skid_cnt     <= 2'd0;
            upload_valid <= 1'b0;
        end else begin
            skid_cnt     <= skid_cnt + 2'(push) - 2'(pop);
            upload_valid <= 1'b0;
            case (state)
                m_idle: begin
                    // pwm wins a tie, the loser is remembered
                    if (pwm_up.req || pend_pwm) begin
                        sel_lb       <= 1'b0;
                        pend_pwm     <= 1'b0;
                        state        <= m_tag;
                        upload_valid <= 1'b1;
                        if (lb_up.req) pend_lb <= 1'b1;
                    end else if (lb_up.req || pend_lb) begin
                        sel_lb       <= 1'b1;
                        pend_lb      <= 1'b0;
                        state        <= m_tag;
                        upload_valid <= 1'b1;
                    end
                end
                m_tag: begin
                    upload_valid <= 1'b1;
                    state        <= m_data;
                end
                default: begin
                    upload_valid <= fwd;
                    if (fwd && out_byte[8]) state <= m_idle;
                end
            endcase
            if (state != m_idle) begin
                if (pwm_up.req) pend_pwm <= 1'b1;
                if (lb_up.req) pend_lb <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            m_idle:  upload_data <= resp_sync;
            m_tag:   upload_data <= sel_lb ? src_loopback : src_pwm;
            default: upload_data <= out_byte[7:0];
        endcase
        if (pop) skid[0] <= skid[1];
        if (push) skid[wr_slot[0]] <= in_byte;
    end

endmodule

`default_nettype wire

// File: hw/usb_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module usb_bridge_top
    import bridge_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              usb_data,
    input  logic                    usb_valid,
    output logic                    parse_error,
    output logic                    led_out,
    output logic [pwm_channels-1:0] pwm_pins,
    output logic [7:0]              upload_data,
    output logic                    upload_valid
);

    logic                      parse_done;
    logic [7:0]                cmd_code;
    logic [15:0]               cmd_len;
    logic [payload_addr_w-1:0] rd_addr;
    logic [7:0]                rd_data;

    cmd_if    i_cmd ();
    upload_if i_pwm_up ();
    upload_if i_lb_up ();

    frame_parser u_parser (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_data     (usb_data),
        .rx_valid    (usb_valid),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .parse_done  (parse_done),
        .parse_error (parse_error),
        .cmd_code    (cmd_code),
        .cmd_len     (cmd_len)
    );

    command_processor u_processor (
        .clk        (clk),
        .rst_n      (rst_n),
        .parse_done (parse_done),
        .cmd_code   (cmd_code),
        .cmd_len    (cmd_len),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .cmd        (i_cmd.source),
        .led_out    (led_out)
    );

    pwm_handler u_pwm (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (i_cmd.sink),
        .up       (i_pwm_up.source),
        .pwm_pins (pwm_pins)
    );

    loopback_handler u_loopback (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (i_cmd.sink),
        .up    (i_lb_up.source)
    );

    upload_merger u_merger (
        .clk          (clk),
        .rst_n        (rst_n),
        .pwm_up       (i_pwm_up.sink),
        .lb_up        (i_lb_up.sink),
        .upload_data  (upload_data),
        .upload_valid (upload_valid)
    );

endmodule

`default_nettype wire

// File: tests/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for 16 cycles, released on a falling edge
    initial begin
        rst_n = 1'b1;
        #1 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/usb_bridge_chk.sv
`timescale 1ns/1ps
`default_nettype none

module usb_bridge_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        cmd_start,
    input logic        cmd_data_valid,
    input logic        cmd_done,
    input logic [15:0] cmd_data_index,
    input logic [15:0] cmd_length,
    input logic        pwm_ready,
    input logic        lb_ready,
    input logic        upload_valid
);

    int          err_cnt = 0;
    // payload bytes seen since the last cmd_start
    logic [15:0] seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen <= 16'd0;
        end else if (cmd_start) begin
            seen <= 16'd0;
        end else if (cmd_data_valid) begin
            seen <= seen + 16'd1;
        end
    end

    // dispatch only while both handlers are free
    a_start_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_start |-> (pwm_ready && lb_ready)
    ) else begin
        $error("cmd_start while a handler ready is low");
        err_cnt++;
    end

    // index counts up from zero within a command
    a_index_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_data_valid |-> (cmd_data_index == seen)
    ) else begin
        $error("cmd_data_index does not match the number of bytes sent");
        err_cnt++;
    end

    a_done_after_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cmd_data_valid && seen == cmd_length - 16'd1) |=> cmd_done
    ) else begin
        $error("cmd_done missing after the last payload byte");
        err_cnt++;
    end

    // done only once the whole payload went out
    a_done_count: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_done |-> (seen == cmd_length) && $past(cmd_data_valid || cmd_start)
    ) else begin
        $error("cmd_done came early or more than once");
        err_cnt++;
    end

    a_reset_quiet: assert property (
        @(posedge clk) !rst_n |-> !upload_valid
    ) else begin
        $error("upload_valid high during reset");
        err_cnt++;
    end

endmodule

`default_nettype wire

// File: tests/tb_usb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_usb_bridge
    import bridge_pkg::*;
();

    localparam int num_frames      = 60;
    localparam int num_directed    = 9;
    localparam int max_gap         = 3;
    localparam int max_frame_bytes = 6 + max_payload + 16;
    localparam int frame_cycles    = max_frame_bytes * (max_gap + 1) + 2 * max_payload + 288;
    localparam int timeout_cycles  = (num_frames + num_directed) * frame_cycles + 1024;

    logic                    clk;
    logic                    rst_n;
    logic [7:0]              usb_data;
    logic                    usb_valid;
    logic                    parse_error;
    logic                    led_out;
    logic [pwm_channels-1:0] pwm_pins;
    logic [7:0]              upload_data;
    logic                    upload_valid;

    logic [31:0] lfsr;
    logic [7:0]  exp_q [$];
    logic [7:0]  pl [80];
    logic [7:0]  duty_m [pwm_channels];
    logic        led_m;
    int          perr_seen = 0;
    int          perr_exp = 0;
    int          err_cnt = 0;
    int          cycles = 0;

    tb_clkgen i_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    usb_bridge_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .usb_data     (usb_data),
        .usb_valid    (usb_valid),
        .parse_error  (parse_error),
        .led_out      (led_out),
        .pwm_pins     (pwm_pins),
        .upload_data  (upload_data),
        .upload_valid (upload_valid)
    );

    bind usb_bridge_top usb_bridge_chk i_chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_start      (i_cmd.cmd_start),
        .cmd_data_valid (i_cmd.cmd_data_valid),
        .cmd_done       (i_cmd.cmd_done),
        .cmd_data_index (i_cmd.cmd_data_index),
        .cmd_length     (i_cmd.cmd_length),
        .pwm_ready      (i_cmd.pwm_ready),
        .lb_ready       (i_cmd.lb_ready),
        .upload_valid   (upload_valid)
    );

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD0000001) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        report_failure($sformatf("[ERROR] %0t %s got 0x%0h expected 0x%0h",
                                 $time, name, got, exp));
    endtask

    task automatic send_byte(input logic [7:0] b);
        repeat (rand_bits(2)) @(negedge clk);
        usb_data  = b;
        usb_valid = 1'b1;
        @(negedge clk);
        usb_valid = 1'b0;
    endtask

    task automatic send_frame(input logic [7:0] code, input int len, input logic bad_sum);
        logic [7:0] sum;
        sum = code + len[15:8] + len[7:0];
        send_byte(sync_byte_0);
        send_byte(sync_byte_1);
        send_byte(code);
        send_byte(len[15:8]);
        send_byte(len[7:0]);
        for (int i = 0; i < len; i++) begin
            sum = sum + pl[i];
            send_byte(pl[i]);
        end
        if (bad_sum) sum = sum ^ (8'h01 << rand_bits(3));
        send_byte(sum);
    endtask

    task automatic send_noise();
        logic [7:0] b;
        int         cnt;
        if (rand_bits(1) != 0) begin
            // stray bytes that never hold a sync value
            cnt = 1 + int'(rand_bits(2));
            repeat (cnt) begin
                b = 8'(rand_bits(8));
                if (b == sync_byte_0 || b == sync_byte_1) b = 8'h00;
                send_byte(b);
            end
        end else begin
            b = 8'(rand_bits(8));
            if (b == sync_byte_0 || b == sync_byte_1) b = 8'h3c;
            send_byte(sync_byte_0);
            send_byte(b);
        end
    endtask

    // every pin high for exactly its duty count per 256 cycles
    task automatic check_pwm_window();
        int high_cnt [pwm_channels];
        for (int k = 0; k < pwm_channels; k++) begin
            high_cnt[k] = 0;
        end
        repeat (256) begin
            @(negedge clk);
            for (int k = 0; k < pwm_channels; k++) begin
                if (pwm_pins[k]) high_cnt[k]++;
            end
        end
        for (int k = 0; k < pwm_channels; k++) begin
            assert (high_cnt[k] == int'(duty_m[k]))
                else report_mismatch($sformatf("pwm_pins[%0d] high cycles", k),
                                     high_cnt[k], int'(duty_m[k]));
        end
    endtask

    task automatic do_frame(input logic [7:0] code, input int len, input logic bad_sum);
        logic ok;
        int   n;
        ok = !bad_sum && len <= max_payload;
        for (int i = 0; i < len; i++) begin
            pl[i] = 8'(rand_bits(8));
        end
        if (!ok) begin
            perr_exp++;
        end else begin
            led_m = ~led_m;
            if (code == cmd_loopback && len > 0) begin
                exp_q.push_back(resp_sync);
                exp_q.push_back(src_loopback);
                for (int i = 0; i < len; i++) begin
                    exp_q.push_back(pl[i]);
                end
            end else if (code == cmd_pwm_set) begin
                n = (len > pwm_channels) ? pwm_channels : len;
                exp_q.push_back(resp_sync);
                exp_q.push_back(src_pwm);
                exp_q.push_back(8'(n));
                for (int k = 0; k < n; k++) begin
                    duty_m[k] = pl[k];
                end
            end
        end
        send_frame(code, len, bad_sum);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (8 + len) @(negedge clk);
        assert (led_out == led_m)
            else report_mismatch("led_out", int'(led_out), int'(led_m));
        assert (perr_seen == perr_exp)
            else report_mismatch("parse_error pulses", perr_seen, perr_exp);
        if (!ok || code == cmd_pwm_set) check_pwm_window();
    endtask

    // upload monitor
    always @(negedge clk) begin
        if (rst_n) begin
            if (parse_error) perr_seen++;
            if (upload_valid) begin
                assert (exp_q.size() != 0)
                    else report_failure("upload byte arrived while no response was expected");
                assert (upload_data == exp_q[0])
                    else report_mismatch("upload_data", int'(upload_data), int'(exp_q[0]));
                void'(exp_q.pop_front());
            end
            assert (i_dut.i_chk.err_cnt == 0)
                else report_failure("a protocol assertion on the DUT failed");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            report_failure($sformatf("timeout, test still running after %0d cycles", cycles));
        end
    end

    initial begin
        int         kind;
        logic [7:0] code;
        lfsr      = 32'h967a15fe;
        usb_data  = 8'h00;
        usb_valid = 1'b0;
        led_m     = 1'b0;
        for (int k = 0; k < pwm_channels; k++) begin
            duty_m[k] = 8'd0;
        end
        @(negedge rst_n);
        @(posedge rst_n);
        @(negedge clk);
        assert (led_out == 1'b0)
            else report_mismatch("led_out", int'(led_out), 0);
        assert (pwm_pins == '0)
            else report_mismatch("pwm_pins", int'(pwm_pins), 0);
        assert (upload_valid == 1'b0)
            else report_mismatch("upload_valid", int'(upload_valid), 0);
        check_pwm_window();

        // directed corner cases first
        do_frame(cmd_loopback, max_payload, 1'b0);
        do_frame(cmd_loopback, 0, 1'b0);
        do_frame(cmd_pwm_set, 12, 1'b0);
        do_frame(cmd_pwm_set, 3, 1'b0);
        do_frame(8'h07, 5, 1'b0);
        do_frame(cmd_loopback, 20, 1'b1);
        do_frame(cmd_pwm_set, max_payload + 6, 1'b0);
        send_noise();
        do_frame(cmd_loopback, 9, 1'b0);
        send_noise();
        do_frame(cmd_pwm_set, 0, 1'b0);

        for (int f = 0; f < num_frames; f++) begin
            kind = int'(rand_bits(3));
            case (kind)
                0, 1, 2: do_frame(cmd_loopback, int'(rand_bits(7)) % 65, 1'b0);
                3, 4: do_frame(cmd_pwm_set, int'(rand_bits(4)), 1'b0);
                5: do_frame(8'h03 + 8'(rand_bits(4)), int'(rand_bits(4)), 1'b0);
                6: begin
                    code = (rand_bits(1) != 0) ? cmd_loopback : cmd_pwm_set;
                    if (rand_bits(1) != 0) do_frame(code, int'(rand_bits(5)), 1'b1);
                    else do_frame(code, max_payload + 1 + int'(rand_bits(3)), 1'b0);
                end
                default: begin
                    send_noise();
                    code = (rand_bits(1) != 0) ? cmd_loopback : cmd_pwm_set;
                    do_frame(code, int'(rand_bits(4)), 1'b0);
                end
            endcase
        end

        if (err_cnt == 0 && i_dut.i_chk.err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/bridge_pkg.sv
hw/cmd_if.sv
hw/upload_if.sv
hw/frame_parser.sv
hw/command_processor.sv
hw/pwm_handler.sv
hw/loopback_handler.sv
hw/upload_merger.sv
hw/usb_bridge_top.sv
tests/tb_clkgen.sv
tests/usb_bridge_chk.sv
tests/tb_usb_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_usb_bridge
RTL_TOP   ?= usb_bridge_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TB PASSED
RTL_FILES ?= $(shell grep '^hw/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)
